/* verilog/coherence_pkg.sv */
`default_nettype none

package coherence_pkg;

    // ----------------------------------------------------------
    // Address layout
    // ----------------------------------------------------------
    localparam int WORD_W   = 32;
    localparam int BYTOFF_W = 2;
    localparam int BLKOFF_W = 1;
    localparam int IDX_W    = 3;
    localparam int TAG_W    = WORD_W - IDX_W - BLKOFF_W - BYTOFF_W;

    localparam int CACHE_SETS  = 1 << IDX_W;     // One frame per index.
    localparam int BLOCK_WORDS = 1 << BLKOFF_W;

    typedef logic [WORD_W-1:0] word_t;

    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [IDX_W-1:0]    idx;
        logic [BLKOFF_W-1:0] blkoff;
        logic [BYTOFF_W-1:0] bytoff;
    } snoop_addr_t;

    // ----------------------------------------------------------
    // Frame and controller state
    // ----------------------------------------------------------
    typedef struct packed {
        logic                         valid;
        logic                         dirty;
        logic [TAG_W-1:0]             tag;
        word_t [BLOCK_WORDS-1:0]      data;  // Indexed by blkoff.
    } dcache_frame_t;

    typedef enum logic [2:0] {
        IDLE,
        WAIT,
        HIT_M_W1,
        HIT_M_W2,
        HIT_S_W1,
        HIT_S_W2
    } snoop_state_t;

endpackage

`default_nettype wire

/* verilog/snoop_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface snoop_if;

    // Lookup side.
    coherence_pkg::snoop_addr_t   snoop_addr;
    logic                         snoop_hit;
    coherence_pkg::dcache_frame_t snoop_frame;

    // Update side, from the snoop controller.
    logic clear_dirty;
    logic clear_valid;
    logic busy;    // Transfer in progress.

    modport dsu (
        input  snoop_addr,
        input  snoop_hit,
        input  snoop_frame,
        output clear_dirty,
        output clear_valid,
        output busy
    );

    modport store (
        input  snoop_addr,
        output snoop_hit,
        output snoop_frame,
        input  clear_dirty,
        input  clear_valid,
        input  busy
    );

endinterface

`default_nettype wire

/* verilog/dcache_frame_store.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_frame_store (
    input  logic                       CLK,
    input  logic                       nRST,
    snoop_if.store                     sif,
    input  logic                       pr_wen,
    input  logic                       pr_dirty,
    input  coherence_pkg::snoop_addr_t pr_addr,
    input  coherence_pkg::word_t       pr_wdata
);

    coherence_pkg::dcache_frame_t frames [coherence_pkg::CACHE_SETS];

    coherence_pkg::dcache_frame_t pr_frame;
    coherence_pkg::dcache_frame_t lookup_frame;
    logic                         wr_en;

    // ----------------------------------------------------------
    // Snoop lookup
    // ----------------------------------------------------------
    assign lookup_frame = frames[sif.snoop_addr.idx];

    assign sif.snoop_frame = lookup_frame;
    assign sif.snoop_hit   = lookup_frame.valid
                             && (lookup_frame.tag == sif.snoop_addr.tag);

    // ----------------------------------------------------------
    // Processor port
    // ----------------------------------------------------------
    assign pr_frame = frames[pr_addr.idx];
    assign wr_en    = pr_wen && !sif.busy;  // Dropped during a transfer.

    always_ff @(posedge CLK, negedge nRST)
    begin
        if (!nRST)
        begin
            frames <= '{default: '0};
        end
        else
        begin
            if (wr_en)
            begin
                frames[pr_addr.idx].valid <= 1'b1;
                frames[pr_addr.idx].tag   <= pr_addr.tag;
                frames[pr_addr.idx].dirty <= pr_frame.dirty | pr_dirty;
                frames[pr_addr.idx].data[pr_addr.blkoff] <= pr_wdata;
            end

            // Snoop side clears, second word only.
            if (sif.clear_dirty)
            begin
                frames[sif.snoop_addr.idx].dirty <= 1'b0;
            end
            if (sif.clear_valid)
            begin
                frames[sif.snoop_addr.idx].valid <= 1'b0;
            end
        end
    end

    // ----------------------------------------------------------
    // Checks
    // ----------------------------------------------------------
    a_valid_clear_with_dirty: assert property (
        @(posedge CLK) disable iff (!nRST)
        sif.clear_valid |-> sif.clear_dirty
    )
    else
        $error("clear_valid without clear_dirty");

    // A write refused during a transfer leaves the frame as it was.
    a_dropped_write: assert property (
        @(posedge CLK) disable iff (!nRST)
        (pr_wen && sif.busy && !sif.clear_dirty)
            |=> (frames[$past(pr_addr.idx)] == $past(pr_frame))
    )
    else
        $error("processor write changed a frame while busy");

    // A write outside a transfer lands in the frame.
    a_write_not_busy: assert property (
        @(posedge CLK) disable iff (!nRST)
        (pr_wen && !sif.busy)
            |=> (frames[$past(pr_addr.idx)].data[$past(pr_addr.blkoff)]
                 == $past(pr_wdata))
    )
    else
        $error("processor write dropped outside a transfer");

endmodule

`default_nettype wire

/* verilog/dcache_snoop_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_snoop_unit (
    input  logic                 CLK,
    input  logic                 nRST,
    snoop_if.dsu                 sif,
    input  logic                 ccwait,
    input  logic                 ccinv,
    input  logic                 mem_ready,
    output logic                 cctrans,
    output logic                 ccwrite,
    output logic                 pr_stall,
    output coherence_pkg::word_t daddr,
    output coherence_pkg::word_t dstore
);

    coherence_pkg::snoop_state_t state;
    coherence_pkg::snoop_state_t nxt_state;

    logic second_word;

    // ----------------------------------------------------------
    // State machine
    // ----------------------------------------------------------
    always_ff @(posedge CLK, negedge nRST)
    begin
        if (!nRST)
            state <= coherence_pkg::IDLE;
        else
            state <= nxt_state;
    end

    always_comb
    begin
        nxt_state = state;
        case (state)
            coherence_pkg::IDLE:
            begin
                if (ccwait && sif.snoop_hit && sif.snoop_frame.dirty)
                    nxt_state = coherence_pkg::HIT_M_W1;
                else if (ccwait && sif.snoop_hit)
                    nxt_state = coherence_pkg::HIT_S_W1;
                else if (ccwait)
                    nxt_state = coherence_pkg::WAIT;  // Miss.
            end
            coherence_pkg::WAIT:
            begin
                if (!ccwait)
                    nxt_state = coherence_pkg::IDLE;
            end
            coherence_pkg::HIT_M_W1:
            begin
                if (mem_ready)
                    nxt_state = coherence_pkg::HIT_M_W2;
            end
            coherence_pkg::HIT_S_W1:
            begin
                if (mem_ready)
                    nxt_state = coherence_pkg::HIT_S_W2;
            end
            coherence_pkg::HIT_M_W2,
            coherence_pkg::HIT_S_W2:
            begin
                if (mem_ready)
                    nxt_state = coherence_pkg::WAIT;
            end
            default:
            begin
                nxt_state = coherence_pkg::IDLE;
            end
        endcase
    end

    // ----------------------------------------------------------
    // Bus and frame outputs
    // ----------------------------------------------------------
    assign second_word = (state == coherence_pkg::HIT_M_W2)
                         || (state == coherence_pkg::HIT_S_W2);

    assign cctrans  = (state != coherence_pkg::IDLE) && (state != coherence_pkg::WAIT);
    assign ccwrite  = (state == coherence_pkg::HIT_M_W1)
                      || (state == coherence_pkg::HIT_M_W2);
    assign pr_stall = cctrans;
    assign sif.busy = cctrans;

    // Block base, word offset inserted, byte offset zero.
    assign daddr  = cctrans ? {sif.snoop_addr.tag, sif.snoop_addr.idx, second_word, 2'b00} : '0;
    assign dstore = cctrans ? sif.snoop_frame.data[second_word] : '0;

    assign sif.clear_dirty = second_word;
    assign sif.clear_valid = second_word && ccinv;

    // ----------------------------------------------------------
    // Checks
    // ----------------------------------------------------------
    a_write_in_trans: assert property (
        @(posedge CLK) disable iff (!nRST)
        ccwrite |-> cctrans
    )
    else
        $error("ccwrite outside a transfer");

    a_hold_on_backpressure: assert property (
        @(posedge CLK) disable iff (!nRST)
        (cctrans && !mem_ready) |=> ($stable(daddr) && $stable(dstore))
    )
    else
        $error("daddr or dstore moved while mem_ready low");

    a_trans_under_wait: assert property (
        @(posedge CLK) disable iff (!nRST)
        cctrans |-> ccwait
    )
    else
        $error("transfer state held with ccwait low");

endmodule

`default_nettype wire

/* verilog/dcache_snoop_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_snoop_top (
    input  logic                       CLK,
    input  logic                       nRST,

    // Coherence controller.
    input  logic                       ccwait,
    input  logic                       ccinv,
    input  coherence_pkg::word_t       ccsnoopaddr,

    // Memory.
    input  logic                       mem_ready,

    // Bus.
    output logic                       cctrans,
    output logic                       ccwrite,
    output coherence_pkg::word_t       daddr,
    output coherence_pkg::word_t       dstore,

    // Processor.
    input  logic                       pr_wen,
    input  logic                       pr_dirty,
    input  coherence_pkg::snoop_addr_t pr_addr,
    input  coherence_pkg::word_t       pr_wdata,
    output logic                       pr_stall
);

    snoop_if sif ();

    assign sif.snoop_addr = coherence_pkg::snoop_addr_t'(ccsnoopaddr);

    // ----------------------------------------------------------
    // Frame array and snoop controller
    // ----------------------------------------------------------
    dcache_frame_store u_store (
        .CLK      (CLK),
        .nRST     (nRST),
        .sif      (sif.store),
        .pr_wen   (pr_wen),
        .pr_dirty (pr_dirty),
        .pr_addr  (pr_addr),
        .pr_wdata (pr_wdata)
    );

    dcache_snoop_unit u_dsu (
        .CLK       (CLK),
        .nRST      (nRST),
        .sif       (sif.dsu),
        .ccwait    (ccwait),
        .ccinv     (ccinv),
        .mem_ready (mem_ready),
        .cctrans   (cctrans),
        .ccwrite   (ccwrite),
        .pr_stall  (pr_stall),
        .daddr     (daddr),
        .dstore    (dstore)
    );

endmodule

`default_nettype wire

/* verif/tb_dcache_snoop.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dcache_snoop;

    typedef enum logic [1:0] {OP_FILL, OP_STORE, OP_SNOOP} op_e;
    typedef enum logic [1:0] {RESP_MISS, RESP_CLEAN, RESP_DIRTY} resp_e;

    typedef struct {
        op_e                  op;
        coherence_pkg::word_t addr;
        coherence_pkg::word_t data;
        logic                 inv;
        resp_e                resp;
        logic                 poke;  // Processor store during the transfer.
    } entry_t;

    localparam int WAIT_LIMIT = 20;

    logic                       CLK;
    logic                       nRST;
    logic                       ccwait;
    logic                       ccinv;
    coherence_pkg::word_t       ccsnoopaddr;
    logic                       mem_ready;
    logic                       cctrans;
    logic                       ccwrite;
    coherence_pkg::word_t       daddr;
    coherence_pkg::word_t       dstore;
    logic                       pr_wen;
    logic                       pr_dirty;
    coherence_pkg::snoop_addr_t pr_addr;
    coherence_pkg::word_t       pr_wdata;
    logic                       pr_stall;

    // Shadow frames.
    logic                             sh_valid [coherence_pkg::CACHE_SETS];
    logic                             sh_dirty [coherence_pkg::CACHE_SETS];
    logic [coherence_pkg::TAG_W-1:0]  sh_tag   [coherence_pkg::CACHE_SETS];
    coherence_pkg::word_t             sh_data  [coherence_pkg::CACHE_SETS][2];

    entry_t tbl [$];
    int     n_checks;
    int     n_errors;
    int     n_timeouts;
    logic   stop_run;

    initial CLK = 1'b0;
    always #4 CLK = ~CLK;

    dcache_snoop_top uut (
        .CLK         (CLK),
        .nRST        (nRST),
        .ccwait      (ccwait),
        .ccinv       (ccinv),
        .ccsnoopaddr (ccsnoopaddr),
        .mem_ready   (mem_ready),
        .cctrans     (cctrans),
        .ccwrite     (ccwrite),
        .daddr       (daddr),
        .dstore      (dstore),
        .pr_wen      (pr_wen),
        .pr_dirty    (pr_dirty),
        .pr_addr     (pr_addr),
        .pr_wdata    (pr_wdata),
        .pr_stall    (pr_stall)
    );

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------
    function automatic coherence_pkg::word_t make_addr(input logic [25:0] tag,
                                                       input logic [2:0] idx,
                                                       input logic blk);
        return {tag, idx, blk, 2'b00};
    endfunction

    task automatic add_entry(input op_e op, input coherence_pkg::word_t addr,
                             input coherence_pkg::word_t data, input logic inv,
                             input resp_e resp, input logic poke);
        entry_t e;
        e = '{op, addr, data, inv, resp, poke};
        tbl.push_back(e);
    endtask

    task automatic check_value(input string name, input coherence_pkg::word_t got,
                               input coherence_pkg::word_t exp);
        n_checks++;
        assert (got === exp)
        else
        begin
            n_errors++;
            $display("ERROR %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
        end
    endtask

    // One cycle on, inputs change on the falling edge.
    task automatic step();
        @(negedge CLK);
        pr_wen = 1'b0;
    endtask

    task automatic write_word(input coherence_pkg::word_t addr,
                              input coherence_pkg::word_t data, input logic dirty);
        coherence_pkg::snoop_addr_t sa;
        sa       = addr;
        pr_addr  = sa;
        pr_wdata = data;
        pr_dirty = dirty;
        pr_wen   = 1'b1;
        step();
        sh_valid[sa.idx]            = 1'b1;
        sh_tag[sa.idx]              = sa.tag;
        sh_data[sa.idx][sa.blkoff]  = data;
        sh_dirty[sa.idx]            = sh_dirty[sa.idx] | dirty;
    endtask

    // Memory side of one word, with random back-pressure.
    task automatic transfer_word(input coherence_pkg::word_t exp_addr,
                                 input coherence_pkg::word_t exp_data,
                                 input logic exp_write, input logic poke,
                                 input coherence_pkg::word_t poke_addr);
        int t;
        int delay;
        t = 0;
        while (!cctrans && t < WAIT_LIMIT)
        begin
            step();
            t++;
        end
        assert (cctrans)
        else
        begin
            n_timeouts++;
            stop_run = 1'b1;
            $display("Timeout: no transfer for word at 0x%08h", exp_addr);
            return;
        end
        check_value("daddr", daddr, exp_addr);
        check_value("dstore", dstore, exp_data);
        check_value("ccwrite", ccwrite, exp_write);
        check_value("pr_stall", pr_stall, 1'b1);
        if (poke)
        begin
            pr_addr  = poke_addr;
            pr_wdata = exp_data ^ 32'h5a5a_0f0f;
            pr_dirty = 1'b1;
            pr_wen   = 1'b1;  // Must be dropped.
        end
        delay = $urandom % 4;
        repeat (delay)
        begin
            step();
            check_value("cctrans", cctrans, 1'b1);
            check_value("ccwrite", ccwrite, exp_write);
            check_value("pr_stall", pr_stall, 1'b1);
            check_value("daddr", daddr, exp_addr);
            check_value("dstore", dstore, exp_data);
        end
        mem_ready = 1'b1;
        step();
        mem_ready = 1'b0;
    endtask

    task automatic wait_idle();
        int t;
        coherence_pkg::snoop_state_t st;
        t  = 0;
        st = uut.u_dsu.state;
        while (st != coherence_pkg::IDLE && t < WAIT_LIMIT)
        begin
            step();
            st = uut.u_dsu.state;
            t++;
        end
        assert (st == coherence_pkg::IDLE)
        else
        begin
            n_timeouts++;
            stop_run = 1'b1;
            $display("Timeout: snoop unit stuck in %s after ccwait dropped", st.name());
        end
    endtask

    task automatic run_snoop(input entry_t e);
        coherence_pkg::snoop_addr_t sa;
        coherence_pkg::word_t       base;
        logic                       hit;
        resp_e                      model;
        sa    = e.addr;
        base  = {e.addr[31:3], 3'b000};
        hit   = sh_valid[sa.idx] && (sh_tag[sa.idx] == sa.tag);
        model = !hit ? RESP_MISS : (sh_dirty[sa.idx] ? RESP_DIRTY : RESP_CLEAN);
        n_checks++;
        assert (model == e.resp)
        else
        begin
            n_errors++;
            $display("Table entry for 0x%08h does not match the shadow frames", e.addr);
        end
        ccsnoopaddr = e.addr;
        ccinv       = e.inv;
        ccwait      = 1'b1;
        if (e.resp == RESP_MISS)
        begin
            repeat (3)
            begin
                step();
                check_value("cctrans", cctrans, 1'b0);
                check_value("ccwrite", ccwrite, 1'b0);
                check_value("pr_stall", pr_stall, 1'b0);
            end
        end
        else
        begin
            transfer_word(base, sh_data[sa.idx][0], e.resp == RESP_DIRTY, e.poke, e.addr);
            if (!stop_run)
                transfer_word(base | 32'h4, sh_data[sa.idx][1], e.resp == RESP_DIRTY,
                              1'b0, e.addr);
            if (!stop_run)
            begin
                check_value("cctrans", cctrans, 1'b0);  // Exactly two words.
                check_value("ccwrite", ccwrite, 1'b0);
                check_value("pr_stall", pr_stall, 1'b0);
            end
            sh_dirty[sa.idx] = 1'b0;
            if (e.inv)
                sh_valid[sa.idx] = 1'b0;
        end
        ccwait = 1'b0;
        if (!stop_run)
            wait_idle();
    endtask

    // ------------------------------------------------------------
    // Stimulus table
    // ------------------------------------------------------------
    task automatic build_table();
        coherence_pkg::word_t a;
        coherence_pkg::word_t b;
        coherence_pkg::word_t e;
        coherence_pkg::word_t f;
        a = make_addr(26'h0123456, 3'd2, 1'b0);
        b = make_addr(26'h2bcdef0, 3'd5, 1'b0);
        e = make_addr(26'h3000abc, 3'd7, 1'b0);
        f = make_addr(26'h0ff00ff, 3'd3, 1'b0);
        // Nothing hits after reset.
        add_entry(OP_SNOOP, make_addr(26'h0, 3'd0, 1'b0), '0, 1'b0, RESP_MISS, 1'b0);
        add_entry(OP_SNOOP, make_addr(26'h2a5a5a5, 3'd7, 1'b1) | 2, '0, 1'b1, RESP_MISS, 1'b0);
        add_entry(OP_STORE, a, 32'h1111_0001, 1'b0, RESP_MISS, 1'b0);
        add_entry(OP_STORE, a | 4, 32'h1111_0002, 1'b0, RESP_MISS, 1'b0);
        add_entry(OP_SNOOP, a, '0, 1'b0, RESP_DIRTY, 1'b0);
        add_entry(OP_SNOOP, a, '0, 1'b0, RESP_CLEAN, 1'b0);   // Dirty was cleared.
        add_entry(OP_SNOOP, a | 7, '0, 1'b1, RESP_CLEAN, 1'b0);
        add_entry(OP_SNOOP, a, '0, 1'b0, RESP_MISS, 1'b0);
        add_entry(OP_FILL, b, 32'h2222_0001, 1'b0, RESP_MISS, 1'b0);
        add_entry(OP_FILL, b | 4, 32'h2222_0002, 1'b0, RESP_MISS, 1'b0);
        add_entry(OP_SNOOP, b, '0, 1'b0, RESP_CLEAN, 1'b1);
        add_entry(OP_SNOOP, b, '0, 1'b0, RESP_CLEAN, 1'b0);
        // Same index as b, other tag.
        add_entry(OP_SNOOP, make_addr(26'h1bcdef0, 3'd5, 1'b0), '0, 1'b0, RESP_MISS, 1'b0);
        add_entry(OP_STORE, e, 32'h3333_0001, 1'b0, RESP_MISS, 1'b0);
        add_entry(OP_STORE, e | 4, 32'h3333_0002, 1'b0, RESP_MISS, 1'b0);
        add_entry(OP_SNOOP, e | 6, '0, 1'b1, RESP_DIRTY, 1'b0);
        add_entry(OP_SNOOP, e, '0, 1'b0, RESP_MISS, 1'b0);
        add_entry(OP_FILL, f, 32'h4444_0001, 1'b0, RESP_MISS, 1'b0);
        add_entry(OP_FILL, f | 4, 32'h4444_0002, 1'b0, RESP_MISS, 1'b0);
        add_entry(OP_STORE, f | 4, 32'h4444_00ff, 1'b0, RESP_MISS, 1'b0);
        add_entry(OP_SNOOP, f, '0, 1'b0, RESP_DIRTY, 1'b1);
        add_entry(OP_SNOOP, f, '0, 1'b0, RESP_CLEAN, 1'b0);
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial
    begin
        void'($urandom(88));
        nRST        = 1'b0;
        ccwait      = 1'b0;
        ccinv       = 1'b0;
        ccsnoopaddr = '0;
        mem_ready   = 1'b0;
        pr_wen      = 1'b0;
        pr_dirty    = 1'b0;
        pr_addr     = '0;
        pr_wdata    = '0;
        n_checks    = 0;
        n_errors    = 0;
        n_timeouts  = 0;
        stop_run    = 1'b0;
        for (int i = 0; i < coherence_pkg::CACHE_SETS; i++)
        begin
            sh_valid[i]   = 1'b0;
            sh_dirty[i]   = 1'b0;
            sh_tag[i]     = '0;
            sh_data[i][0] = '0;
            sh_data[i][1] = '0;
        end
        build_table();

        repeat (2) @(negedge CLK);
        nRST = 1'b1;
        step();
        check_value("cctrans", cctrans, 1'b0);
        check_value("ccwrite", ccwrite, 1'b0);
        check_value("pr_stall", pr_stall, 1'b0);

        foreach (tbl[i])
        begin
            if (stop_run)
                break;
            case (tbl[i].op)
                OP_FILL:  write_word(tbl[i].addr, tbl[i].data, 1'b0);
                OP_STORE: write_word(tbl[i].addr, tbl[i].data, 1'b1);
                default:  run_snoop(tbl[i]);
            endcase
        end

        $display("Checks %0d, errors %0d, timeouts %0d", n_checks, n_errors, n_timeouts);
        if (n_errors == 0 && n_timeouts == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
verilog/coherence_pkg.sv
verilog/snoop_if.sv
verilog/dcache_frame_store.sv
verilog/dcache_snoop_unit.sv
verilog/dcache_snoop_top.sv
verif/tb_dcache_snoop.sv

/* Bender.yml */
package:
  name: dcache_snoop

sources:
  # Design, in compile order.
  - files:
      - verilog/coherence_pkg.sv
      - verilog/snoop_if.sv
      - verilog/dcache_frame_store.sv
      - verilog/dcache_snoop_unit.sv
      - verilog/dcache_snoop_top.sv

  # Testbench.
  - target: test
    files:
      - verif/tb_dcache_snoop.sv
